// File: hdl/arith_pkg.sv
////////////////////////////////////////
// shared opcodes, engine states and APB register map
// offsets are byte addresses on an 8-bit paddr
// every register is one 32-bit word, full-word writes only
////////////////////////////////////////

package arith_pkg;

    typedef enum logic [1:0] {
        OP_DIVU = 2'd0,
        OP_DIV  = 2'd1,
        OP_MULU = 2'd2,
        OP_MUL  = 2'd3
    } arith_op_e;

    // both engines walk through the same four states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_LOAD = 2'd1,
        ST_CALC = 2'd2,
        ST_DONE = 2'd3
    } engine_state_e;

    localparam logic [7:0] ADDR_CTRL   = 8'h00;
    localparam logic [7:0] ADDR_OPA    = 8'h04;
    localparam logic [7:0] ADDR_OPB    = 8'h08;
    localparam logic [7:0] ADDR_STATUS = 8'h0C;
    localparam logic [7:0] ADDR_RES_LO = 8'h10;
    localparam logic [7:0] ADDR_RES_HI = 8'h14;

    localparam int CTRL_START_BIT = 8; // write one, self clearing

endpackage

// File: hdl/arith_if.sv
////////////////////////////////////////
// request/response link between the
// register block and one engine
// start only while busy is low, results
// stay put from done until next start
////////////////////////////////////////

`timescale 1ns/1ps

interface arith_if #(
    parameter int DATA_WIDTH = 8
) ();

    logic                    start;     // one-cycle pulse
    logic                    op_signed;
    logic [DATA_WIDTH-1 : 0] op_a;
    logic [DATA_WIDTH-1 : 0] op_b;
    logic [DATA_WIDTH-1 : 0] res_lo;
    logic [DATA_WIDTH-1 : 0] res_hi;
    logic                    done;      // one-cycle pulse
    logic                    busy;
    logic                    div_zero;  // divider only

    modport ctrl (
        output start, op_signed, op_a, op_b,
        input  res_lo, res_hi, done, busy, div_zero
    );

    modport engine (
        input  start, op_signed, op_a, op_b,
        output res_lo, res_hi, done, busy, div_zero
    );

endinterface

// File: hdl/seq_divider.sv
////////////////////////////////////////
// restoring shift-subtract divider, one quotient bit per cycle
// done comes DATA_WIDTH+2 cycles after start, 2 cycles on a zero divisor
// zero divisor: quotient all ones, remainder = dividend, div_zero set
// signed min / -1 wraps to min with remainder 0
// res_lo = quotient, res_hi = remainder
////////////////////////////////////////

`timescale 1ns/1ps

module seq_divider
    import arith_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) (
    input  logic    i_clk,
    input  logic    i_rst_n,
    arith_if.engine bus
);

    localparam int CNT_W = $clog2(DATA_WIDTH);
    localparam int MSB   = DATA_WIDTH - 1;
    localparam int MSB2  = 2 * DATA_WIDTH - 1;

    engine_state_e state;
    logic [CNT_W-1 : 0] cnt;
    logic dz;

    logic [MSB2 : 0] part_rem;  // upper half stays clear
    logic [MSB2 : 0] div_sh;    // divisor, walks right one bit per step
    logic [MSB2 : 0] diff;
    logic [MSB : 0]  quot;
    logic [MSB : 0]  a_abs;
    logic [MSB : 0]  b_abs;
    logic            q_neg;
    logic            r_neg;
    logic            b_zero;

    assign a_abs  = (bus.op_signed && bus.op_a[MSB]) ? (~bus.op_a + 1'b1) : bus.op_a;
    assign b_abs  = (bus.op_signed && bus.op_b[MSB]) ? (~bus.op_b + 1'b1) : bus.op_b;
    assign diff   = part_rem - div_sh;
    assign b_zero = (div_sh == '0);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
            cnt   <= '0;
            dz    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (bus.start) begin
                        state <= ST_LOAD;
                        dz    <= 1'b0;
                    end
                end
                ST_LOAD: begin
                    cnt <= '0;
                    if (b_zero) begin
                        state <= ST_DONE;   // nothing to iterate
                        dz    <= 1'b1;
                    end else begin
                        state <= ST_CALC;
                    end
                end
                ST_CALC: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(DATA_WIDTH - 1)) state <= ST_DONE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        case (state)
            ST_IDLE: begin
                if (bus.start) begin
                    part_rem <= {{DATA_WIDTH{1'b0}}, a_abs};
                    div_sh   <= {1'b0, b_abs, {(DATA_WIDTH - 1){1'b0}}};
                    q_neg    <= bus.op_signed & (bus.op_a[MSB] ^ bus.op_b[MSB]);
                    r_neg    <= bus.op_signed & bus.op_a[MSB]; // follows dividend
                end
            end
            ST_LOAD: begin
                // zero divisor: all ones out unnegated, remainder sign restores dividend
                quot <= b_zero ? '1 : '0;
                if (b_zero) q_neg <= 1'b0;
            end
            ST_CALC: begin
                quot   <= {quot[MSB-1 : 0], ~diff[MSB2]};
                div_sh <= div_sh >> 1;
                if (!diff[MSB2]) part_rem <= diff;  // keep on no borrow
            end
            default: begin
            end
        endcase
    end

    assign bus.res_lo   = q_neg ? (~quot + 1'b1) : quot;
    assign bus.res_hi   = r_neg ? (~part_rem[MSB : 0] + 1'b1) : part_rem[MSB : 0];
    assign bus.done     = (state == ST_DONE);
    assign bus.busy     = (state != ST_IDLE);
    assign bus.div_zero = dz;

    // the register block must hold off a new start while we run
    a_no_start_busy: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) bus.start |-> !bus.busy
    );

endmodule

// File: hdl/seq_multiplier.sv
////////////////////////////////////////
// shift-add multiplier, one multiplier bit per cycle
// done comes DATA_WIDTH+2 cycles after start
// full double-width product split over res_hi:res_lo
////////////////////////////////////////

`timescale 1ns/1ps

module seq_multiplier
    import arith_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) (
    input  logic    i_clk,
    input  logic    i_rst_n,
    arith_if.engine bus
);

    localparam int CNT_W = $clog2(DATA_WIDTH);
    localparam int MSB   = DATA_WIDTH - 1;
    localparam int MSB2  = 2 * DATA_WIDTH - 1;

    engine_state_e state;
    logic [CNT_W-1 : 0] cnt;

    logic [MSB2 : 0] mcand;     // shifted left each step
    logic [MSB2 : 0] acc;
    logic [MSB2 : 0] prod;
    logic [MSB : 0]  mplier;
    logic [MSB : 0]  a_abs;
    logic [MSB : 0]  b_abs;
    logic            p_neg;

    assign a_abs = (bus.op_signed && bus.op_a[MSB]) ? (~bus.op_a + 1'b1) : bus.op_a;
    assign b_abs = (bus.op_signed && bus.op_b[MSB]) ? (~bus.op_b + 1'b1) : bus.op_b;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: if (bus.start) state <= ST_LOAD;
                ST_LOAD: begin
                    cnt   <= '0;
                    state <= ST_CALC;
                end
                ST_CALC: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(DATA_WIDTH - 1)) state <= ST_DONE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        case (state)
            ST_IDLE: begin
                if (bus.start) begin
                    mcand  <= {{DATA_WIDTH{1'b0}}, a_abs};
                    mplier <= b_abs;
                    p_neg  <= bus.op_signed & (bus.op_a[MSB] ^ bus.op_b[MSB]);
                end
            end
            ST_LOAD: acc <= '0;
            ST_CALC: begin
                if (mplier[0]) acc <= acc + mcand;
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
            end
            default: begin
            end
        endcase
    end

    assign prod = p_neg ? (~acc + 1'b1) : acc;

    assign bus.res_lo   = prod[MSB : 0];
    assign bus.res_hi   = prod[MSB2 : DATA_WIDTH];
    assign bus.done     = (state == ST_DONE);
    assign bus.busy     = (state != ST_IDLE);
    assign bus.div_zero = 1'b0;             // no such case here

    // each done pulse answers the start pulse DATA_WIDTH+2 cycles earlier
    a_done_pulse: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) bus.done |-> $past(bus.start, DATA_WIDTH + 2)
    );

endmodule

// File: hdl/apb_arith_regs.sv
////////////////////////////////////////
// APB register block, zero wait states
// pslverr on unmapped address or start while busy
// CTRL writes are dropped while busy
// results are zero-extended to 32 bits
////////////////////////////////////////

`timescale 1ns/1ps

module apb_arith_regs
    import arith_pkg::*;
#(
    parameter int DATA_WIDTH = 8
) (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  logic          i_psel,
    input  logic          i_penable,
    input  logic          i_pwrite,
    input  logic [7 : 0]  i_paddr,
    input  logic [31 : 0] i_pwdata,
    output logic [31 : 0] o_prdata,
    output logic          o_pslverr,
    arith_if.ctrl         div_bus,
    arith_if.ctrl         mul_bus
);

    localparam int PAD = 32 - DATA_WIDTH;

    arith_op_e op_q;
    logic [DATA_WIDTH-1 : 0] opa_q;
    logic [DATA_WIDTH-1 : 0] opb_q;
    logic [31 : 0] res_lo_q;
    logic [31 : 0] res_hi_q;
    logic start_q;
    logic run_q;    // set at accepted start, covers gap before engine busy
    logic done_q;
    logic dz_q;

    logic access;
    logic wr_en;
    logic addr_ok;
    logic stat_busy;
    logic start_req;
    logic ctrl_wr;
    logic sel_div;

    assign access    = i_psel & i_penable;
    assign wr_en     = access & i_pwrite;
    assign stat_busy = run_q | div_bus.busy | mul_bus.busy;
    assign start_req = wr_en & (i_paddr == ADDR_CTRL) & i_pwdata[CTRL_START_BIT];
    assign ctrl_wr   = wr_en & (i_paddr == ADDR_CTRL) & !stat_busy;
    assign sel_div   = (op_q == OP_DIVU) || (op_q == OP_DIV);
    assign o_pslverr = access & (!addr_ok | (start_req & stat_busy));

    always_comb begin
        addr_ok = 1'b1;
        case (i_paddr)
            ADDR_CTRL:   o_prdata = {30'b0, op_q};  // start always reads 0
            ADDR_OPA:    o_prdata = {{PAD{1'b0}}, opa_q};
            ADDR_OPB:    o_prdata = {{PAD{1'b0}}, opb_q};
            ADDR_STATUS: o_prdata = {29'b0, dz_q, done_q, stat_busy};
            ADDR_RES_LO: o_prdata = res_lo_q;
            ADDR_RES_HI: o_prdata = res_hi_q;
            default: begin
                o_prdata = 32'b0;
                addr_ok  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            op_q     <= OP_DIVU;
            start_q  <= 1'b0;
            run_q    <= 1'b0;
            done_q   <= 1'b0;
            dz_q     <= 1'b0;
            res_lo_q <= 32'b0;
            res_hi_q <= 32'b0;
        end else begin
            start_q <= ctrl_wr & i_pwdata[CTRL_START_BIT];
            if (ctrl_wr) op_q <= arith_op_e'(i_pwdata[1 : 0]);
            if (ctrl_wr && i_pwdata[CTRL_START_BIT]) begin
                run_q  <= 1'b1;
                done_q <= 1'b0;
                dz_q   <= 1'b0;
            end else if (div_bus.done) begin
                run_q    <= 1'b0;
                done_q   <= 1'b1;
                dz_q     <= div_bus.div_zero;
                res_lo_q <= {{PAD{1'b0}}, div_bus.res_lo};
                res_hi_q <= {{PAD{1'b0}}, div_bus.res_hi};
            end else if (mul_bus.done) begin
                run_q    <= 1'b0;
                done_q   <= 1'b1;
                res_lo_q <= {{PAD{1'b0}}, mul_bus.res_lo};
                res_hi_q <= {{PAD{1'b0}}, mul_bus.res_hi};
            end
        end
    end

    // engines latch operands on their start, so later writes are harmless
    always_ff @(posedge i_clk) begin
        if (wr_en && i_paddr == ADDR_OPA) opa_q <= i_pwdata[DATA_WIDTH-1 : 0];
        if (wr_en && i_paddr == ADDR_OPB) opb_q <= i_pwdata[DATA_WIDTH-1 : 0];
    end

    assign div_bus.start     = start_q & sel_div;
    assign mul_bus.start     = start_q & !sel_div;
    assign div_bus.op_signed = (op_q == OP_DIV) || (op_q == OP_MUL);
    assign mul_bus.op_signed = div_bus.op_signed;
    assign div_bus.op_a      = opa_q;
    assign div_bus.op_b      = opb_q;
    assign mul_bus.op_a      = opa_q;
    assign mul_bus.op_b      = opb_q;

    a_one_engine: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(div_bus.busy && mul_bus.busy)
    );

endmodule

// File: hdl/apb_arith_top.sv
////////////////////////////////////////
// APB arithmetic unit, divider and multiplier
// DATA_WIDTH from 4 to 16
// one operation in flight, poll STATUS for done
////////////////////////////////////////

`timescale 1ns/1ps

module apb_arith_top #(
    parameter int DATA_WIDTH = 8
) (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  logic          i_psel,
    input  logic          i_penable,
    input  logic          i_pwrite,
    input  logic [7 : 0]  i_paddr,
    input  logic [31 : 0] i_pwdata,
    output logic [31 : 0] o_prdata,
    output logic          o_pslverr
);

    arith_if #(.DATA_WIDTH(DATA_WIDTH)) div_bus ();
    arith_if #(.DATA_WIDTH(DATA_WIDTH)) mul_bus ();

    apb_arith_regs #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_regs (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pslverr (o_pslverr),
        .div_bus   (div_bus),
        .mul_bus   (mul_bus)
    );

    seq_divider #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_div (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .bus     (div_bus)
    );

    seq_multiplier #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_mul (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .bus     (mul_bus)
    );

endmodule

// File: verif/tb_apb_arith.sv
////////////////////////////////////////
// directed testbench for apb_arith_top
// tasks start and end 1 ns after a clock edge
// APB read data and pslverr sampled at the
// falling edge of the access cycle
////////////////////////////////////////

`timescale 1ns/1ps

module tb_apb_arith
    import arith_pkg::*;
();

    localparam int DW     = 8;
    localparam int N_RAND = 8;
    localparam int N_OPS  = 16 + 4 * N_RAND + 4;  // directed, random, busy and error tests
    localparam int LIMIT  = N_OPS * (DW + 4 + 20);

    logic          i_clk;
    logic          i_rst_n;
    logic          i_psel;
    logic          i_penable;
    logic          i_pwrite;
    logic [7 : 0]  i_paddr;
    logic [31 : 0] i_pwdata;
    logic [31 : 0] o_prdata;
    logic          o_pslverr;

    int checks;
    int errors;
    int cycles;
    integer seed;

    apb_arith_top #(.DATA_WIDTH(DW)) uut (.*);

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: no result after %0d cycles", LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic expect_eq(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("error at %0t: %s", $time, what);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        i_psel   = 1'b1;        // setup phase
        i_pwrite = 1'b1;
        i_paddr  = addr;
        i_pwdata = data;
        @(posedge i_clk);
        #1 i_penable = 1'b1;
        @(negedge i_clk);
        err = o_pslverr;
        @(posedge i_clk);
        #1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        i_psel   = 1'b1;
        i_pwrite = 1'b0;
        i_paddr  = addr;
        @(posedge i_clk);
        #1 i_penable = 1'b1;
        @(negedge i_clk);
        data = o_prdata;
        err  = o_pslverr;
        @(posedge i_clk);
        #1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    // expected results straight from the arithmetic rules
    function automatic void model_result(input arith_op_e op, input logic [DW-1:0] a,
            input logic [DW-1:0] b, output logic [DW-1:0] lo, output logic [DW-1:0] hi,
            output logic dz);
        longint sa;
        longint sb;
        longint p;
        logic   sgn;
        sgn = (op == OP_DIV) || (op == OP_MUL);
        sa  = sgn ? longint'($signed(a)) : longint'(a);
        sb  = sgn ? longint'($signed(b)) : longint'(b);
        dz  = 1'b0;
        if (op == OP_MULU || op == OP_MUL) begin
            p  = sa * sb;
            lo = p[DW-1 : 0];
            hi = p[2*DW-1 : DW];
        end else if (b == '0) begin
            dz = 1'b1;
            lo = '1;
            hi = a;
        end else if (sgn && a == {1'b1, {(DW-1){1'b0}}} && b == '1) begin
            lo = a;                 // overflow wraps to most negative
            hi = '0;
        end else begin
            lo = DW'(sa / sb);      // truncates toward zero
            hi = DW'(sa % sb);
        end
    endfunction

    task automatic collect_and_check(input arith_op_e op, input logic [DW-1:0] a,
                                     input logic [DW-1:0] b);
        logic [31:0]   st;
        logic [31:0]   lo;
        logic [31:0]   hi;
        logic          err;
        logic [DW-1:0] elo;
        logic [DW-1:0] ehi;
        logic          edz;
        do begin
            apb_read(ADDR_STATUS, st, err);
        end while (st[1] !== 1'b1);
        apb_read(ADDR_RES_LO, lo, err);
        apb_read(ADDR_RES_HI, hi, err);
        model_result(op, a, b, elo, ehi, edz);
        expect_eq($sformatf("%s %h,%h status", op.name(), a, b), st, {29'b0, edz, 2'b10});
        expect_eq($sformatf("%s %h,%h res_lo", op.name(), a, b), lo, 32'(elo));
        expect_eq($sformatf("%s %h,%h res_hi", op.name(), a, b), hi, 32'(ehi));
    endtask

    task automatic run_op(input arith_op_e op, input logic [DW-1:0] a,
                          input logic [DW-1:0] b);
        logic err;
        apb_write(ADDR_OPA, 32'(a), err);
        apb_write(ADDR_OPB, 32'(b), err);
        apb_write(ADDR_CTRL, 32'h100 | 32'(op), err);
        expect_true(!err, "start write refused while idle");
        collect_and_check(op, a, b);
    endtask

    task automatic check_after_reset();
        logic [31:0] rd;
        logic        err;
        expect_true(!o_pslverr, "pslverr high after reset");
        apb_read(ADDR_STATUS, rd, err);
        expect_eq("status after reset", rd, 32'h0);
        apb_read(ADDR_RES_LO, rd, err);
        expect_eq("res_lo after reset", rd, 32'h0);
        apb_read(ADDR_RES_HI, rd, err);
        expect_eq("res_hi after reset", rd, 32'h0);
        expect_true(!err, "pslverr on a mapped read");
    endtask

    task automatic random_ops(input arith_op_e op);
        for (int i = 0; i < N_RAND; i++) begin
            run_op(op, DW'($random(seed)), DW'($random(seed)));
        end
    endtask

    task automatic divide_directed();
        run_op(OP_DIVU, DW'(100), DW'(7));
        run_op(OP_DIVU, DW'(255), DW'(1));
        run_op(OP_DIVU, DW'(7), DW'(100));
        run_op(OP_DIVU, DW'(255), DW'(255));
        run_op(OP_DIVU, DW'(0), DW'(5));
        run_op(OP_DIV, DW'(-100), DW'(7));
        run_op(OP_DIV, DW'(100), DW'(-7));
        run_op(OP_DIV, DW'(-100), DW'(-7));
        run_op(OP_DIV, {1'b1, {(DW-1){1'b0}}}, '1);    // min / -1
        run_op(OP_DIV, {1'b1, {(DW-1){1'b0}}}, DW'(1));
        run_op(OP_DIV, DW'(5), DW'(-128));
        run_op(OP_DIVU, DW'(200), DW'(0));              // zero divisors
        run_op(OP_DIV, DW'(-50), DW'(0));
        run_op(OP_DIV, DW'(0), DW'(0));
    endtask

    task automatic busy_and_unmapped();
        logic [31:0] rd;
        logic        err;
        apb_write(ADDR_OPA, 32'd200, err);
        apb_write(ADDR_OPB, 32'd9, err);
        apb_write(ADDR_CTRL, 32'h100 | 32'(OP_DIVU), err);
        expect_true(!err, "start write refused while idle");
        apb_write(ADDR_CTRL, 32'h100 | 32'(OP_MUL), err);
        expect_true(err, "start write while busy gave no pslverr");
        collect_and_check(OP_DIVU, DW'(200), DW'(9));
        apb_read(8'h18, rd, err);
        expect_true(err, "unmapped read gave no pslverr");
        apb_write(8'h40, 32'h1234, err);
        expect_true(err, "unmapped write gave no pslverr");
    endtask

    initial begin
        i_clk     = 1'b0;
        i_rst_n   = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = 8'h0;
        i_pwdata  = 32'h0;
        checks    = 0;
        errors    = 0;
        cycles    = 0;
        seed      = 17;
        repeat (4) @(posedge i_clk);
        #1 i_rst_n = 1'b1;
        check_after_reset();
        divide_directed();
        random_ops(OP_DIVU);
        random_ops(OP_DIV);
        run_op(OP_MULU, '1, '1);
        run_op(OP_MUL, {1'b1, {(DW-1){1'b0}}}, {1'b1, {(DW-1){1'b0}}});
        random_ops(OP_MULU);
        random_ops(OP_MUL);
        busy_and_unmapped();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: files.f
hdl/arith_pkg.sv
hdl/arith_if.sv
hdl/seq_divider.sv
hdl/seq_multiplier.sv
hdl/apb_arith_regs.sv
hdl/apb_arith_top.sv
verif/tb_apb_arith.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_apb_arith
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
